/* rename_core.f */
core_pkg.sv
free_list.sv
rename_map.sv
reorder_buffer.sv
phys_regfile.sv
rename_core.sv
rename_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rename core testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module rename_core_tb \
    -f rename_core.f -o sim_rename_core > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_rename_core > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* rename_core_tb.sv */
// rename_core testbench: clock, reset, reference model, stimulus and checking assertions
`timescale 1ns/1ps

module rename_core_tb;
    import core_pkg::*;

    localparam int TIMEOUT = 200;

    logic      clock;
    logic      reset;
    logic      dispatch;
    arch_idx_t dispatch_dest;
    arch_idx_t dispatch_src1;
    arch_idx_t dispatch_src2;
    logic      complete;
    rob_idx_t  complete_rob_tag;
    word_t     complete_data;
    logic      stall;
    phys_idx_t src1_tag;
    logic      src1_ready;
    phys_idx_t src2_tag;
    logic      src2_ready;
    phys_idx_t dest_tag;
    rob_idx_t  rob_tag;
    logic      commit;
    arch_idx_t commit_arch;
    word_t     commit_data;

    rename_core dut0 (.*);

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    phys_idx_t map_m   [NUM_ARCH_REGS];
    logic      ready_m [NUM_PHYS_REGS];
    phys_idx_t free_q  [$];
    // in-order entries, indexed by rob slot
    arch_idx_t m_arch [ROB_DEPTH];
    phys_idx_t m_phys [ROB_DEPTH];
    phys_idx_t m_old  [ROB_DEPTH];
    logic      m_done [ROB_DEPTH];
    word_t     m_data [ROB_DEPTH];
    rob_idx_t  m_head;
    rob_idx_t  m_tail;
    int        m_count;

    // expectations for the coming rising edge
    logic      exp_stall;
    logic      exp_commit;
    arch_idx_t exp_arch;
    word_t     exp_data;
    phys_idx_t exp_dest;
    rob_idx_t  exp_rob;
    phys_idx_t exp_s1;
    phys_idx_t exp_s2;
    logic      exp_r1;
    logic      exp_r2;

    int    seed = 4036;
    int    value_errors = 0;
    int    other_errors = 0;
    int    dispatched = 0;
    string test_name = "reset";

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic reset_model();
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            map_m[i] = phys_idx_t'(i);
        end
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            ready_m[i] = 1'b1;
        end
        free_q.delete();
        // everything above the identity map, in order
        for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
            free_q.push_back(phys_idx_t'(i));
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            m_done[i] = 1'b0;
        end
        m_head  = '0;
        m_tail  = '0;
        m_count = 0;
    endtask

    // state at cycle start plus the inputs now driven
    task automatic compute_expect();
        exp_stall  = (m_count == ROB_DEPTH) || (free_q.size() == 0);
        exp_commit = (m_count != 0) && m_done[m_head];
        exp_arch   = m_arch[m_head];
        exp_data   = m_data[m_head];
        exp_dest   = (free_q.size() != 0) ? free_q[0] : '0;
        exp_rob    = m_tail;
        // sources see the old mapping, no same-cycle forwarding
        exp_s1 = map_m[dispatch_src1];
        exp_s2 = map_m[dispatch_src2];
        exp_r1 = ready_m[exp_s1];
        exp_r2 = ready_m[exp_s2];
    endtask

    // effects of the edge just passed
    task automatic apply_model();
        phys_idx_t new_reg;
        if (complete) begin
            ready_m[m_phys[complete_rob_tag]] = 1'b1;
            m_done[complete_rob_tag] = 1'b1;
            m_data[complete_rob_tag] = complete_data;
        end
        // clear after set, rename wins on a clash
        if (dispatch) begin
            new_reg = free_q.pop_front();
            m_arch[m_tail] = dispatch_dest;
            m_phys[m_tail] = new_reg;
            m_old[m_tail]  = map_m[dispatch_dest];
            m_done[m_tail] = 1'b0;
            map_m[dispatch_dest] = new_reg;
            ready_m[new_reg] = 1'b0;
            m_tail = m_tail + rob_idx_t'(1);
            m_count++;
            dispatched++;
        end
        // head retired, old mapping back to the free list
        if (exp_commit) begin
            free_q.push_back(m_old[m_head]);
            m_head = m_head + rob_idx_t'(1);
            m_count--;
        end
    endtask

    // one clock, inputs driven at the falling edge
    task automatic run_cycle();
        compute_expect();
        @(negedge clock);
        apply_model();
        dispatch = 1'b0;
        complete = 1'b0;
    endtask

    task automatic drive_dispatch(input arch_idx_t dest, input arch_idx_t s1,
                                  input arch_idx_t s2);
        dispatch      = 1'b1;
        dispatch_dest = dest;
        dispatch_src1 = s1;
        dispatch_src2 = s2;
    endtask

    task automatic random_dispatch();
        drive_dispatch(arch_idx_t'($random(seed)), arch_idx_t'($random(seed)),
                       arch_idx_t'($random(seed)));
    endtask

    task automatic drive_complete(input rob_idx_t tag);
        complete         = 1'b1;
        complete_rob_tag = tag;
        complete_data    = $random(seed);
    endtask

    // random live entry that has not completed, -1 if none
    task automatic pick_pending(output int slot);
        int       pending [$];
        rob_idx_t s;
        for (int i = 0; i < m_count; i++) begin
            s = m_head + rob_idx_t'(i);
            if (!m_done[s]) begin
                pending.push_back(int'(s));
            end
        end
        slot = -1;
        if (pending.size() != 0) begin
            slot = pending[$unsigned($random(seed)) % pending.size()];
        end
    endtask

    // complete in random order until everything has committed
    task automatic drain();
        int slot;
        int cycles;
        cycles = 0;
        while (m_count != 0 && cycles < TIMEOUT) begin
            pick_pending(slot);
            if (slot >= 0) begin
                drive_complete(rob_idx_t'(slot));
            end
            run_cycle();
            cycles++;
        end
        if (m_count != 0) begin
            other_errors++;
            $display("timeout in %s: entries never committed", test_name);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_stall : assert property (@(posedge clock) disable iff (reset)
        stall == exp_stall
    ) else begin
        value_errors++;
        $display("** Error [%s] stall: expected %0b, actual %0b",
                 test_name, exp_stall, $sampled(stall));
    end

    a_commit : assert property (@(posedge clock) disable iff (reset)
        commit == exp_commit
    ) else begin
        value_errors++;
        $display("** Error [%s] commit: expected %0b, actual %0b",
                 test_name, exp_commit, $sampled(commit));
    end

    // architectural index and data of the retiring entry
    a_commit_payload : assert property (@(posedge clock) disable iff (reset)
        exp_commit |-> ({commit_arch, commit_data} == {exp_arch, exp_data})
    ) else begin
        value_errors++;
        $display("** Error [%s] commit arch/data: expected %0d/%h, actual %0d/%h",
                 test_name, exp_arch, exp_data, $sampled(commit_arch), $sampled(commit_data));
    end

    a_dest : assert property (@(posedge clock) disable iff (reset)
        dispatch |-> ({dest_tag, rob_tag} == {exp_dest, exp_rob})
    ) else begin
        value_errors++;
        $display("** Error [%s] dest_tag/rob_tag: expected %0d/%0d, actual %0d/%0d",
                 test_name, exp_dest, exp_rob, $sampled(dest_tag), $sampled(rob_tag));
    end

    // tag and ready bit of both sources
    a_sources : assert property (@(posedge clock) disable iff (reset)
        dispatch |-> ({src1_tag, src1_ready, src2_tag, src2_ready}
                      == {exp_s1, exp_r1, exp_s2, exp_r2})
    ) else begin
        value_errors++;
        $display("** Error [%s] src tag/ready: expected %0d/%0b %0d/%0b, actual %0d/%0b %0d/%0b",
                 test_name, exp_s1, exp_r1, exp_s2, exp_r2, $sampled(src1_tag),
                 $sampled(src1_ready), $sampled(src2_tag), $sampled(src2_ready));
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int       cycles;
        int       slot;
        rob_idx_t prod;
        reset            = 1'b1;
        dispatch         = 1'b0;
        dispatch_dest    = '0;
        dispatch_src1    = '0;
        dispatch_src2    = '0;
        complete         = 1'b0;
        complete_rob_tag = '0;
        complete_data    = '0;
        reset_model();
        compute_expect();
        repeat (8) @(negedge clock);
        reset = 1'b0;

        // idle, then first rename off the identity map
        test_name = "reset_first_dispatch";
        run_cycle();
        drive_dispatch(5'd5, 5'd1, 5'd2);
        run_cycle();

        // x3 producer, then consumers before and after its completion
        test_name = "dependency";
        prod = m_tail;
        drive_dispatch(5'd3, 5'd1, 5'd2);
        run_cycle();
        drive_dispatch(5'd4, 5'd3, 5'd3);
        run_cycle();
        // completing now, ready only from the next cycle
        drive_complete(prod);
        drive_dispatch(5'd6, 5'd3, 5'd0);
        run_cycle();
        drive_dispatch(5'd7, 5'd3, 5'd4);
        run_cycle();
        drain();

        test_name = "random_order";
        repeat (8) begin
            random_dispatch();
            run_cycle();
        end
        drain();

        // sixteen in flight with nothing complete
        test_name = "fill_stall";
        cycles = 0;
        while (!stall && cycles < TIMEOUT) begin
            random_dispatch();
            run_cycle();
            cycles++;
        end
        if (!stall) begin
            other_errors++;
            $display("timeout in %s: stall never rose", test_name);
        end
        drive_complete(m_head);
        run_cycle();
        cycles = 0;
        while (stall && cycles < TIMEOUT) begin
            run_cycle();
            cycles++;
        end
        if (stall) begin
            other_errors++;
            $display("timeout in %s: stall never fell", test_name);
        end
        drain();

        // steady stream, well past the first 32 free registers
        test_name = "recycling";
        repeat (48) begin
            if (!stall) begin
                random_dispatch();
            end
            pick_pending(slot);
            if (slot >= 0 && ($random(seed) % 2) == 0) begin
                drive_complete(rob_idx_t'(slot));
            end
            run_cycle();
        end
        drain();
        if (dispatched <= FREE_LIST_DEPTH) begin
            other_errors++;
            $display("recycled registers were never allocated");
        end
        run_cycle();

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* rename_core.sv */
// rename_core: top level joining free list, map, reorder buffer and register file
`timescale 1ns/1ps

module rename_core (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch,
    input  core_pkg::arch_idx_t dispatch_dest,
    input  core_pkg::arch_idx_t dispatch_src1,
    input  core_pkg::arch_idx_t dispatch_src2,
    input  logic                complete,
    input  core_pkg::rob_idx_t  complete_rob_tag,
    input  core_pkg::word_t     complete_data,
    output logic                stall,
    output core_pkg::phys_idx_t src1_tag,
    output logic                src1_ready,
    output core_pkg::phys_idx_t src2_tag,
    output logic                src2_ready,
    output core_pkg::phys_idx_t dest_tag,
    output core_pkg::rob_idx_t  rob_tag,
    output logic                commit,
    output core_pkg::arch_idx_t commit_arch,
    output core_pkg::word_t     commit_data
);
    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    logic      fl_empty;
    logic      rob_full;
    phys_idx_t old_tag;
    // cdb from the reorder buffer
    logic      cdb_valid;
    phys_idx_t cdb_tag;
    word_t     cdb_data;
    // retirement
    phys_idx_t retire_phys;
    phys_idx_t retire_old;

    // no room for another instruction
    assign stall = rob_full | fl_empty;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    // head register is the new destination mapping
    free_list free_list0 (
        .clock       (clock),
        .reset       (reset),
        .dequeue     (dispatch),
        .enqueue     (commit),
        .enqueue_idx (retire_old),
        .head_idx    (dest_tag),
        .empty       (fl_empty)
    );

    rename_map rename_map0 (
        .clock      (clock),
        .reset      (reset),
        .src1       (dispatch_src1),
        .src2       (dispatch_src2),
        .dest       (dispatch_dest),
        .rename     (dispatch),
        .new_tag    (dest_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .src1_tag   (src1_tag),
        .src1_ready (src1_ready),
        .src2_tag   (src2_tag),
        .src2_ready (src2_ready),
        .old_tag    (old_tag)
    );

    reorder_buffer reorder_buffer0 (
        .clock            (clock),
        .reset            (reset),
        .dispatch         (dispatch),
        .dispatch_dest    (dispatch_dest),
        .new_tag          (dest_tag),
        .old_tag          (old_tag),
        .complete         (complete),
        .complete_rob_tag (complete_rob_tag),
        .complete_data    (complete_data),
        .full             (rob_full),
        .rob_tag          (rob_tag),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_data         (cdb_data),
        .retire           (commit),
        .retire_arch      (commit_arch),
        .retire_phys      (retire_phys),
        .retire_old       (retire_old)
    );

    // written by the cdb, read for the committing entry
    phys_regfile phys_regfile0 (
        .clock      (clock),
        .write      (cdb_valid),
        .write_idx  (cdb_tag),
        .write_data (cdb_data),
        .read_idx   (retire_phys),
        .read_data  (commit_data)
    );

endmodule

/* phys_regfile.sv */
// phys_regfile: physical register storage, one cdb write port, one retire read port
`timescale 1ns/1ps

module phys_regfile (
    input  logic                clock,
    input  logic                write,
    input  core_pkg::phys_idx_t write_idx,
    input  core_pkg::word_t     write_data,
    input  core_pkg::phys_idx_t read_idx,
    output core_pkg::word_t     read_data
);
    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // unwritten entries stay unknown, never committed
    word_t regs [NUM_PHYS_REGS];

    // cdb write, visible after the edge
    always_ff @(posedge clock) begin
        if (write) begin
            regs[write_idx] <= write_data;
        end
    end

    // retire read, no bypass needed
    // head is complete only after its cdb write landed
    assign read_data = regs[read_idx];

endmodule

/* reorder_buffer.sv */
// reorder_buffer: in-order entry queue, out-of-order completion, cdb and retire
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch,
    input  core_pkg::arch_idx_t dispatch_dest,
    input  core_pkg::phys_idx_t new_tag,
    input  core_pkg::phys_idx_t old_tag,
    input  logic                complete,
    input  core_pkg::rob_idx_t  complete_rob_tag,
    input  core_pkg::word_t     complete_data,
    output logic                full,
    output core_pkg::rob_idx_t  rob_tag,
    output logic                cdb_valid,
    output core_pkg::phys_idx_t cdb_tag,
    output core_pkg::word_t     cdb_data,
    output logic                retire,
    output core_pkg::arch_idx_t retire_arch,
    output core_pkg::phys_idx_t retire_phys,
    output core_pkg::phys_idx_t retire_old
);
    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // entry storage and pointers
    ////////////////////////////////////////////////////////////

    rob_entry_t entries [ROB_DEPTH];
    // oldest entry
    rob_idx_t   head;
    // next free slot
    rob_idx_t   tail;
    rob_count_t count;

    // distance of the completing slot from head
    rob_idx_t   complete_offset;
    logic       complete_in_range;

    assign full    = (count == rob_count_t'(ROB_DEPTH));
    // tag handed out to this cycle's dispatch
    assign rob_tag = tail;

    // slot is live when it lies within count of head
    assign complete_offset   = complete_rob_tag - head;
    assign complete_in_range = (rob_count_t'(complete_offset) < count);

    ////////////////////////////////////////////////////////////
    // common data bus
    ////////////////////////////////////////////////////////////

    // completion turns straight into a broadcast, no buffering
    assign cdb_valid = complete;
    assign cdb_tag   = entries[complete_rob_tag].phys;
    assign cdb_data  = complete_data;

    ////////////////////////////////////////////////////////////
    // retirement
    ////////////////////////////////////////////////////////////

    // head leaves in the first cycle it shows complete
    assign retire      = (count != '0) && entries[head].complete;
    assign retire_arch = entries[head].arch;
    assign retire_phys = entries[head].phys;
    // goes back to the free list
    assign retire_old  = entries[head].old_phys;

    ////////////////////////////////////////////////////////////
    // pointer and count update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch) begin
                tail <= tail + rob_idx_t'(1);
            end
            if (retire) begin
                head <= head + rob_idx_t'(1);
            end
            count <= count + rob_count_t'(dispatch) - rob_count_t'(retire);
        end
    end

    // entry payload, allocation clears the complete flag
    always_ff @(posedge clock) begin
        if (dispatch) begin
            entries[tail].arch     <= dispatch_dest;
            entries[tail].phys     <= new_tag;
            entries[tail].old_phys <= old_tag;
            entries[tail].complete <= 1'b0;
        end
        // never the tail slot, that one is not yet dispatched
        if (complete) begin
            entries[complete_rob_tag].complete <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // dispatch must honour stall from the top level
    a_no_dispatch_full : assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> !full
    ) else $error("reorder_buffer: dispatch while full");

    // completion may only name a live entry
    a_complete_live : assert property (
        @(posedge clock) disable iff (reset)
        complete |-> complete_in_range
    ) else $error("reorder_buffer: completion of an empty slot");

    // each entry completes exactly once
    a_complete_once : assert property (
        @(posedge clock) disable iff (reset)
        complete |-> !entries[complete_rob_tag].complete
    ) else $error("reorder_buffer: completion of an already complete slot");

endmodule

/* rename_map.sv */
// rename_map: speculative architectural to physical map and ready scoreboard
`timescale 1ns/1ps

module rename_map (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::arch_idx_t src1,
    input  core_pkg::arch_idx_t src2,
    input  core_pkg::arch_idx_t dest,
    input  logic                rename,
    input  core_pkg::phys_idx_t new_tag,
    input  logic                cdb_valid,
    input  core_pkg::phys_idx_t cdb_tag,
    output core_pkg::phys_idx_t src1_tag,
    output logic                src1_ready,
    output core_pkg::phys_idx_t src2_tag,
    output logic                src2_ready,
    output core_pkg::phys_idx_t old_tag
);
    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////

    // current mapping of each arch reg
    phys_idx_t map [NUM_ARCH_REGS];
    // one bit per phys reg, set once its value is on the cdb
    logic [NUM_PHYS_REGS-1:0] ready;

    ////////////////////////////////////////////////////////////
    // lookups
    ////////////////////////////////////////////////////////////

    // sources read the map before this cycle's dest update
    assign src1_tag = map[src1];
    assign src2_tag = map[src2];

    // ready as of cycle start, same-cycle cdb not forwarded
    assign src1_ready = ready[src1_tag];
    assign src2_ready = ready[src2_tag];

    // mapping being replaced, kept by the reorder buffer
    assign old_tag = map[dest];

    ////////////////////////////////////////////////////////////
    // updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, all values present
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= phys_idx_t'(i);
            end
            ready <= '1;
        end else begin
            // result broadcast
            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end
            // new producer, written last so the clear wins on a clash
            if (rename) begin
                map[dest]      <= new_tag;
                ready[new_tag] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a broadcast tag belongs to an in-flight entry, so it is still pending
    a_cdb_pending : assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> !ready[cdb_tag]
    ) else $error("rename_map: cdb broadcast for a register already ready");

    // a recycled register was produced by a retired entry, so it is ready
    a_alloc_ready : assert property (
        @(posedge clock) disable iff (reset)
        rename |-> ready[new_tag]
    ) else $error("rename_map: allocated register still pending");

endmodule

/* free_list.sv */
// free_list: circular queue of free physical register indices
`timescale 1ns/1ps

module free_list (
    input  logic                clock,
    input  logic                reset,
    input  logic                dequeue,
    input  logic                enqueue,
    input  core_pkg::phys_idx_t enqueue_idx,
    output core_pkg::phys_idx_t head_idx,
    output logic                empty
);
    import core_pkg::*;

    ////////////////////////////////////////////////////////////
    // queue storage and pointers
    ////////////////////////////////////////////////////////////

    phys_idx_t slots [FREE_LIST_DEPTH];
    fl_idx_t   head;
    fl_idx_t   tail;
    fl_count_t count;

    // next free register, valid only while not empty
    assign head_idx = slots[head];
    assign empty    = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            // everything above the identity map starts free, in order
            for (int i = 0; i < FREE_LIST_DEPTH; i++) begin
                slots[i] <= phys_idx_t'(NUM_ARCH_REGS + i);
            end
            head  <= '0;
            // queue full, so tail sits on head
            tail  <= '0;
            count <= fl_count_t'(FREE_LIST_DEPTH);
        end else begin
            // dispatch consumes the head
            if (dequeue) begin
                head <= head + fl_idx_t'(1);
            end
            // retirement returns an old mapping at the tail
            if (enqueue) begin
                slots[tail] <= enqueue_idx;
                tail        <= tail + fl_idx_t'(1);
            end
            // both in one cycle leaves count unchanged
            count <= count + fl_count_t'(enqueue) - fl_count_t'(dequeue);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // top level must stall dispatch while no register is free
    a_no_dequeue_empty : assert property (
        @(posedge clock) disable iff (reset)
        dequeue |-> !empty
    ) else $error("free_list: dequeue while empty");

    // more frees than registers means a double retirement upstream
    a_no_enqueue_full : assert property (
        @(posedge clock) disable iff (reset)
        (enqueue && !dequeue) |-> (count != fl_count_t'(FREE_LIST_DEPTH))
    ) else $error("free_list: enqueue while full");

endmodule

/* core_pkg.sv */
// sizes, index types and reorder buffer entry for the rename and retire core
package core_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // data path width
    localparam int XLEN            = 32;
    localparam int NUM_ARCH_REGS   = 32;
    localparam int NUM_PHYS_REGS   = 64;
    localparam int ROB_DEPTH       = 16;
    // every phys reg not held by the initial identity map
    localparam int FREE_LIST_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

    // index widths
    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS);
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS);
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);
    localparam int FL_IDX_W   = $clog2(FREE_LIST_DEPTH);

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [PHYS_IDX_W-1:0] phys_idx_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    // free list slot pointer, wraps at depth
    typedef logic [FL_IDX_W-1:0] fl_idx_t;

    // occupancy counters, one extra bit to hold the full value
    typedef logic [FL_IDX_W:0]  fl_count_t;
    typedef logic [ROB_IDX_W:0] rob_count_t;

    // one reorder buffer slot, 18 bits
    typedef struct packed {
        arch_idx_t arch;
        // register written by this instruction
        phys_idx_t phys;
        // mapping it replaced, freed at retirement
        phys_idx_t old_phys;
        logic      complete;
    } rob_entry_t;

endpackage
